// ==== sim.f ====
source/fetch_pkg.sv
source/imem_pkg.sv
source/access_timer.sv
source/imem_ram.sv
source/fetch_ctrl.sv
source/pc_gen.sv
source/fetch_top.sv
tests/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  # packages first
  - source/fetch_pkg.sv
  - source/imem_pkg.sv
  # rtl
  - source/access_timer.sv
  - source/imem_ram.sv
  - source/fetch_ctrl.sv
  - source/pc_gen.sv
  - source/fetch_top.sv
  # testbench
  - target: test
    files:
      - tests/fetch_tb.sv

// ==== tests/fetch_tb.sv ====
// testbench for the fetch front end: random program load, xorshift stimulus,
// reference model of memory and fetch stream, compare tasks and run limit
`timescale 1ns/10ps

module fetch_tb
  import fetch_pkg::*;
  import imem_pkg::*;
();

  ////////////////////
  // test lengths
  ////////////////////

  localparam int N_SEQ       = 8;
  localparam int N_JMP       = 4;
  localparam int N_PRED      = 2;
  localparam int N_FLIGHT    = 4;
  localparam int RUN_LEN     = 3;
  localparam int IDLE_CYCLES = 20;
  localparam int N_REQ       = N_SEQ + (N_JMP + N_PRED + N_FLIGHT) * RUN_LEN;
  localparam int CYCLE_LIMIT = 200 * N_REQ + 2000;

  logic       clk;
  logic       rst;
  logic       i_next;
  logic       i_jmp;
  addr_t      i_jmp_addr;
  imem_load_t i_load;
  fetch_out_t o_fetch;

  fetch_top u_fetch_top (
    .clk        (clk),
    .rst        (rst),
    .i_next     (i_next),
    .i_jmp      (i_jmp),
    .i_jmp_addr (i_jmp_addr),
    .i_load     (i_load),
    .o_fetch    (o_fetch)
  );

  // reference model
  inst_t       model_mem [IMEM_WORDS];
  addr_t       m_pc;
  addr_t       m_pred;
  addr_t       m_target;
  logic        m_refetch;

  logic [31:0] rng_state;
  fetch_out_t  seen_q [$];
  int          cycle_cnt    = 0;
  int          pc_errors    = 0;
  int          inst_errors  = 0;
  int          lat_errors   = 0;
  int          other_errors = 0;

  always #2 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: fetch did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // word-aligned target that differs from the prediction
  function automatic addr_t random_target();
    addr_t t;
    t = {next_random(), next_random()} & ~64'h3;
    while (t == m_pred) begin
      t = {next_random(), next_random()} & ~64'h3;
    end
    return t;
  endfunction

  // one cycle, outputs sampled at the falling edge
  task automatic tick();
    @(negedge clk);
    if (o_fetch.valid !== 1'b0) begin
      seen_q.push_back(o_fetch);
    end
  endtask

  task automatic model_jump(input addr_t target);
    if (target != m_pred) begin
      m_refetch = 1'b1;
      m_target  = target;
    end
  endtask

  // next delivered pc and word
  task automatic model_expect(output addr_t pc, output inst_t inst);
    if (m_refetch) begin
      m_pc      = m_target;
      m_refetch = 1'b0;
    end
    pc     = m_pc;
    inst   = model_mem[m_pc[IMEM_AW+1:2]];
    m_pc   = m_pc + 64'd4;
    m_pred = m_pc;
  endtask

  task automatic check_pc(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("mismatch %s pc expected %h actual %h", name, exp, act);
      pc_errors++;
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (exp !== act) begin
      $display("mismatch %s inst expected %h actual %h", name, exp, act);
      inst_errors++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch %s latency expected %0d actual %0d", name, exp, act);
      lat_errors++;
    end
  endtask

  task automatic load_memory();
    inst_t word;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      word           = next_random();
      model_mem[i]   = word;
      i_load.we      = 1'b1;
      i_load.addr    = PC_START + 64'(i * 4);
      i_load.data    = word;
      tick();
    end
    i_load = '0;
    tick();
  endtask

  task automatic issue_jump(input addr_t target);
    i_jmp      = 1'b1;
    i_jmp_addr = target;
    model_jump(target);
    tick();
    i_jmp = 1'b0;
    tick();
  endtask

  // one i_next, optional redirect while the access is in flight
  task automatic run_request(input string name, input logic in_flight, input addr_t target);
    fetch_out_t got;
    addr_t      exp_pc;
    inst_t      exp_inst;
    int         wait_cycles;
    int         exp_wait;
    i_next = 1'b1;
    tick();
    i_next = 1'b0;
    wait_cycles = 1;
    if (in_flight) begin
      tick();
      i_jmp      = 1'b1;
      i_jmp_addr = target;
      model_jump(target);
      tick();
      i_jmp = 1'b0;
      wait_cycles = 3;
    end
    // req one cycle after i_next, ack WAIT_STATES+1 later, result one cycle after
    // a pending redirect adds one more access started right after the ack
    if (m_refetch) begin
      exp_wait = 2 * int'(WAIT_STATES) + 5;
    end else begin
      exp_wait = int'(WAIT_STATES) + 3;
    end
    while (seen_q.size() == 0) begin
      tick();
      wait_cycles++;
    end
    got = seen_q.pop_front();
    model_expect(exp_pc, exp_inst);
    check_pc(name, exp_pc, got.pc);
    check_inst(name, exp_inst, got.inst);
    check_latency(name, exp_wait, wait_cycles);
    // no second pulse without a new request
    repeat (IDLE_CYCLES) tick();
    if (seen_q.size() != 0) begin
      $display("%s: %0d extra o_fetch pulses without a new request", name, seen_q.size());
      other_errors++;
      seen_q.delete();
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    i_next     = 1'b0;
    i_jmp      = 1'b0;
    i_jmp_addr = '0;
    i_load     = '0;
    rng_state  = 32'h1e0434be;
    m_pc       = PC_START;
    m_pred     = PC_START;
    m_target   = '0;
    m_refetch  = 1'b0;

    repeat (3) tick();
    rst = 1'b0;
    load_memory();
    if (seen_q.size() != 0) begin
      $display("o_fetch.valid pulsed during reset or memory load");
      other_errors++;
      seen_q.delete();
    end

    for (int i = 0; i < N_SEQ; i++) begin
      run_request($sformatf("sequential_%0d", i), 1'b0, '0);
    end

    // redirect between requests
    for (int r = 0; r < N_JMP; r++) begin
      issue_jump(random_target());
      for (int k = 0; k < RUN_LEN; k++) begin
        run_request($sformatf("jump_between_%0d_%0d", r, k), 1'b0, '0);
      end
    end

    // redirect to the predicted pc changes nothing
    for (int r = 0; r < N_PRED; r++) begin
      issue_jump(m_pred);
      for (int k = 0; k < RUN_LEN; k++) begin
        run_request($sformatf("jump_predicted_%0d_%0d", r, k), 1'b0, '0);
      end
    end

    // redirect during an access
    for (int r = 0; r < N_FLIGHT; r++) begin
      run_request($sformatf("jump_in_flight_%0d", r), 1'b1, random_target());
      for (int k = 1; k < RUN_LEN; k++) begin
        run_request($sformatf("after_flight_%0d_%0d", r, k), 1'b0, '0);
      end
    end

    $display("errors: pc %0d inst %0d latency %0d other %0d",
             pc_errors, inst_errors, lat_errors, other_errors);
    if (pc_errors + inst_errors + lat_errors + other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== source/fetch_top.sv ====
// fetch front end top: control FSM, pc unit
// and instruction memory
`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
  import imem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // consumer requests and redirects
  input  logic       i_next,
  input  logic       i_jmp,
  input  addr_t      i_jmp_addr,

  // memory preload
  input  imem_load_t i_load,

  // delivered instruction
  output fetch_out_t o_fetch
);

  ////////////////////
  // internal wiring
  ////////////////////

  imem_req_t mem_req;
  imem_rsp_t mem_rsp;
  logic      ctrl_req;
  logic      accept;
  logic      refetch;
  addr_t     fetch_addr;

  // request level from the FSM, address from the pc unit
  assign mem_req.req  = ctrl_req;
  assign mem_req.addr = fetch_addr;

  fetch_ctrl u_fetch_ctrl (
    .clk       (clk),
    .rst       (rst),
    .i_next    (i_next),
    .i_rsp     (mem_rsp),
    .o_req     (ctrl_req),
    .i_refetch (refetch),
    .o_accept  (accept)
  );

  pc_gen u_pc_gen (
    .clk        (clk),
    .rst        (rst),
    .i_accept   (accept),
    .i_rdata    (mem_rsp.rdata),
    .i_jmp      (i_jmp),
    .i_jmp_addr (i_jmp_addr),
    .o_addr     (fetch_addr),
    .o_refetch  (refetch),
    .o_fetch    (o_fetch)
  );

  // memory answers through its own wait-state timer
  imem_ram u_imem_ram (
    .clk    (clk),
    .i_load (i_load),
    .i_req  (mem_req),
    .o_rsp  (mem_rsp)
  );

endmodule

// ==== source/pc_gen.sv ====
// pc unit: fetch address, predicted pc, pending redirect
// and the registered fetch result
`timescale 1ns/10ps

module pc_gen
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       i_accept,
  input  inst_t      i_rdata,

  // redirect from the consumer
  input  logic       i_jmp,
  input  addr_t      i_jmp_addr,

  output addr_t      o_addr,
  output logic       o_refetch,
  output fetch_out_t o_fetch
);

  addr_t      addr_q;
  addr_t      pred_q;
  addr_t      target_q;
  logic       refetch_q;
  logic       redirect;
  fetch_out_t fetch_q;

  // jump to the predicted pc needs no action
  assign redirect = i_jmp && (i_jmp_addr != pred_q);

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q        <= PC_START;
      pred_q        <= PC_START;
      refetch_q     <= 1'b0;
      fetch_q.valid <= 1'b0;
    end else begin
      fetch_q.valid <= i_accept && !refetch_q;
      if (i_accept) begin
        if (refetch_q) begin
          // stale word dropped, restart at the saved target
          refetch_q <= 1'b0;
          addr_q    <= target_q;
          pred_q    <= target_q + 64'd4;
        end else begin
          addr_q    <= addr_q + 64'd4;
          pred_q    <= addr_q + 64'd4;
        end
      end
      // a new redirect wins over the clear above
      if (redirect) begin
        refetch_q <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (redirect) begin
      target_q <= i_jmp_addr;
    end
    if (i_accept && !refetch_q) begin
      fetch_q.pc   <= addr_q;
      fetch_q.inst <= i_rdata;
    end
  end

  assign o_addr    = addr_q;
  assign o_refetch = refetch_q;
  assign o_fetch   = fetch_q;

endmodule

// ==== source/fetch_ctrl.sv ====
// fetch control FSM: raises the memory request on i_next
// and flags each accepted access
`timescale 1ns/10ps

module fetch_ctrl
  import fetch_pkg::*;
  import imem_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // consumer side
  input  logic      i_next,

  // memory handshake
  input  imem_rsp_t i_rsp,
  output logic      o_req,

  // pc unit side
  input  logic      i_refetch,
  output logic      o_accept
);

  fetch_state_t state_q;
  fetch_state_t state_d;

  ////////////////////
  // handshake
  ////////////////////

  // request is a pure function of the state
  assign o_req = (state_q == S_REQ);

  // req and ack both high closes one access
  assign o_accept = o_req & i_rsp.ack;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        // wait for the consumer
        if (i_next) begin
          state_d = S_REQ;
        end
      end
      S_REQ: begin
        // a pending redirect keeps req high for one more access
        if (o_accept && !i_refetch) begin
          state_d = S_DONE;
        end
      end
      S_DONE: begin
        // result is out this cycle, a new i_next may start right away
        if (i_next) begin
          state_d = S_REQ;
        end else begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== source/imem_ram.sv ====
// instruction memory: word array with a load port
// and a read port acknowledged through the wait-state timer
`timescale 1ns/10ps

module imem_ram
  import fetch_pkg::*;
  import imem_pkg::*;
(
  input  logic       clk,

  // program preload
  input  imem_load_t i_load,

  // fetch port
  input  imem_req_t  i_req,
  output imem_rsp_t  o_rsp
);

  inst_t     mem [IMEM_WORDS];
  imem_idx_t wr_idx;
  imem_idx_t rd_idx;
  logic      timer_clr;
  logic      timer_start;
  logic      timer_busy;
  logic      timer_expire;

  // word index, upper address bits ignored
  assign wr_idx = i_load.addr[IMEM_AW+1:2];
  assign rd_idx = i_req.addr[IMEM_AW+1:2];

  ////////////////////
  // load port
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_load.we) begin
      mem[wr_idx] <= i_load.data;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // timer is held clear while no request is raised
  assign timer_clr = !i_req.req;

  // new access only when the previous one is fully over
  assign timer_start = i_req.req && !timer_busy && !timer_expire;

  access_timer u_access_timer (
    .clk      (clk),
    .rst      (timer_clr),
    .i_start  (timer_start),
    .o_busy   (timer_busy),
    .o_expire (timer_expire)
  );

  assign o_rsp.ack   = timer_expire;
  assign o_rsp.rdata = mem[rd_idx];

endmodule

// ==== source/access_timer.sv ====
// wait-state timer: loads on start, counts down,
// one-cycle expire pulse at zero
`timescale 1ns/10ps

module access_timer
  import imem_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  output logic o_busy,
  output logic o_expire
);

  logic [3:0] cnt_q;
  logic       run_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
      run_q <= 1'b0;
    end else if (i_start) begin
      cnt_q <= WAIT_STATES;
      run_q <= 1'b1;
    end else if (run_q) begin
      if (cnt_q == '0) begin
        // expire cycle just passed
        run_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 4'd1;
      end
    end
  end

  // still counting
  assign o_busy = run_q && (cnt_q != '0);

  // last cycle of the access
  assign o_expire = run_q && (cnt_q == '0);

endmodule

// ==== source/imem_pkg.sv ====
// instruction memory bus: request, response and load port structs
// memory depth, word index width and wait-state count
package imem_pkg;

  import fetch_pkg::*;

  ////////////////////
  // geometry
  ////////////////////

  // number of 32-bit words
  localparam int IMEM_WORDS = 256;

  // word index taken from address bits 9..2
  localparam int IMEM_AW = 8;

  typedef logic [IMEM_AW-1:0] imem_idx_t;

  // extra cycles before each acknowledge
  localparam logic [3:0] WAIT_STATES = 4'd3;

  ////////////////////
  // bus structs
  ////////////////////

  // req is held high until the ack cycle
  typedef struct packed {
    logic  req;
    addr_t addr;
  } imem_req_t;

  // ack is a one-cycle pulse, rdata valid with it
  typedef struct packed {
    logic  ack;
    inst_t rdata;
  } imem_rsp_t;

  // write port used to preload the program
  typedef struct packed {
    logic  we;
    addr_t addr;
    inst_t data;
  } imem_load_t;

endpackage

// ==== source/fetch_pkg.sv ====
// fetch side types: address and instruction words, fetch result
// reset fetch address and control state encoding
package fetch_pkg;

  ////////////////////
  // widths
  ////////////////////

  // byte address as seen by the core
  typedef logic [63:0] addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] inst_t;

  // first fetch address after reset
  localparam addr_t PC_START = 64'h0000_0000_8000_0000;

  ////////////////////
  // fetch result
  ////////////////////

  // one delivered instruction, valid is a single-cycle pulse
  typedef struct packed {
    logic  valid;
    addr_t pc;
    inst_t inst;
  } fetch_out_t;

  // fetch control FSM
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_REQ  = 2'd1,
    S_DONE = 2'd2
  } fetch_state_t;

endpackage
